/* src/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   // --------------------
   // Plain vector types
   // --------------------
   typedef logic [31:0] word_t;
   typedef logic [31:0] byte_addr_t;
   typedef logic [29:0] word_addr_t;
   // Bit 3 is the lowest byte address (big-endian)
   typedef logic [3:0]  byte_en_t;
   typedef logic [5:0]  opcode_t;

   // MIPS major opcodes handled by the memory stage
   localparam opcode_t OP_LB  = 6'h20;
   localparam opcode_t OP_LH  = 6'h21;
   localparam opcode_t OP_LW  = 6'h23;
   localparam opcode_t OP_LBU = 6'h24;
   localparam opcode_t OP_LHU = 6'h25;
   localparam opcode_t OP_SB  = 6'h28;
   localparam opcode_t OP_SH  = 6'h29;
   localparam opcode_t OP_SW  = 6'h2B;

   // --------------------
   // Cache geometry
   // --------------------
   // 8 words per line, 32 lines per way, 4 ways
   localparam int WORD_INDEX_BITS = 3;
   localparam int LINE_INDEX_BITS = 5;
   localparam int WAY_BITS        = 2;
   // Only the low 1 MiB is cached
   localparam int CACHEABLE_BITS  = 20;
   localparam int TAG_BITS = CACHEABLE_BITS - LINE_INDEX_BITS - WORD_INDEX_BITS - 2;

   typedef logic [WORD_INDEX_BITS-1:0] word_index_t;
   typedef logic [LINE_INDEX_BITS-1:0] line_index_t;
   typedef logic [WAY_BITS-1:0]        way_t;
   typedef logic [TAG_BITS-1:0]        tag_t;

   // Miss handling FSM
   typedef enum logic [1:0] {
      S_IDLE,
      S_DRAIN,
      S_FILL_REQ,
      S_FILL
   } ctrl_state_t;

endpackage

`default_nettype wire

/* src/dcache_align.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_align
   import dcache_pkg::*;
(
   input  opcode_t    store_op,
   input  logic [1:0] store_byte,
   input  word_t      store_data,
   output word_t      store_lanes,
   output byte_en_t   store_byteena,
   input  opcode_t    load_op,
   input  logic [1:0] load_byte,
   input  word_t      read_word,
   output word_t      load_result
);

   logic [15:0] load_half;
   logic [7:0]  load_bits;

   // --------------------
   // Store lanes
   // --------------------
   // Replicate narrow data so the enables alone pick the lane
   always_comb begin
      case (store_op)
         OP_SB: begin
            store_lanes   = {4{store_data[7:0]}};
            store_byteena = 4'b1000 >> store_byte;
         end
         OP_SH: begin
            store_lanes   = {2{store_data[15:0]}};
            // Big-endian, offset 0 is the upper half
            store_byteena = store_byte[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            store_lanes   = store_data;
            store_byteena = 4'b1111;
         end
      endcase
   end

   // --------------------
   // Load extraction
   // --------------------
   assign load_half = load_byte[1] ? read_word[15:0] : read_word[31:16];
   assign load_bits = load_byte[0] ? load_half[7:0] : load_half[15:8];

   always_comb begin
      case (load_op)
         OP_LB:   load_result = {{24{load_bits[7]}}, load_bits};
         OP_LBU:  load_result = {24'h0, load_bits};
         OP_LH:   load_result = {{16{load_half[15]}}, load_half};
         OP_LHU:  load_result = {16'h0, load_half};
         // Full word, also the don't-care value on stores
         default: load_result = read_word;
      endcase
   end

endmodule

`default_nettype wire

/* src/store_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module store_buffer
   import dcache_pkg::*;
#(
   parameter int SB_DEPTH_BITS = 3
) (
   input  logic       clock,
   input  logic       reset,
   input  logic       push,
   input  word_addr_t push_address,
   input  word_t      push_data,
   input  byte_en_t   push_byteena,
   input  logic       pop,
   output logic       full,
   output logic       empty,
   output word_addr_t head_address,
   output word_t      head_data,
   output byte_en_t   head_byteena
);

   localparam int DEPTH = 1 << SB_DEPTH_BITS;

   word_addr_t               address_q [DEPTH];
   word_t                    data_q    [DEPTH];
   byte_en_t                 byteena_q [DEPTH];
   logic [SB_DEPTH_BITS-1:0] wr_ptr;
   logic [SB_DEPTH_BITS-1:0] rd_ptr;
   logic [SB_DEPTH_BITS-1:0] wr_ptr_next;

   // One slot stays empty, so full and empty need no extra bit
   assign wr_ptr_next = wr_ptr + 1'b1;
   assign empty = wr_ptr == rd_ptr;
   assign full  = wr_ptr_next == rd_ptr;

   // --------------------
   // Pointers
   // --------------------
   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr_next;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Entry storage
   always_ff @(posedge clock) begin
      if (push) begin
         address_q[wr_ptr] <= push_address;
         data_q[wr_ptr]    <= push_data;
         byteena_q[wr_ptr] <= push_byteena;
      end
   end

   // Oldest store feeds the memory write port
   assign head_address = address_q[rd_ptr];
   assign head_data    = data_q[rd_ptr];
   assign head_byteena = byteena_q[rd_ptr];

   // Full stores must have been restarted upstream
   a_no_overflow: assert property (@(posedge clock) disable iff (reset)
      push |-> !full);

   a_no_underflow: assert property (@(posedge clock) disable iff (reset)
      pop |-> !empty);

endmodule

`default_nettype wire

/* src/dcache_tags.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_tags
   import dcache_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  line_index_t lookup_index,
   input  tag_t        lookup_tag,
   input  way_t        fill_way,
   input  line_index_t fill_index,
   input  tag_t        fill_tag,
   input  logic        tag_invalidate,
   input  logic        tag_write,
   output logic        hit,
   output way_t        hit_way
);

   localparam int NUM_WAYS  = 1 << WAY_BITS;
   localparam int NUM_LINES = 1 << LINE_INDEX_BITS;

   logic [NUM_WAYS-1:0] hits;

   // --------------------
   // One tag array per way
   // --------------------
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      tag_t                 tag_ram [NUM_LINES];
      logic [NUM_LINES-1:0] valid;
      tag_t                 rd_tag;
      logic                 rd_valid;
      logic                 selected;

      assign selected = fill_way == way_t'(w);

      // Tag is written once, on the last fill beat
      always_ff @(posedge clock) begin
         if (tag_write && selected)
            tag_ram[fill_index] <= fill_tag;
         rd_tag <= tag_ram[lookup_index];
      end

      // Invalidate at fill start, set again with the tag
      always_ff @(posedge clock) begin
         if (reset) begin
            valid    <= '0;
            rd_valid <= 1'b0;
         end else begin
            if (selected && (tag_write || tag_invalidate))
               valid[fill_index] <= tag_write;
            rd_valid <= valid[lookup_index];
         end
      end

      assign hits[w] = rd_valid && rd_tag == lookup_tag;
   end

   // --------------------
   // Hit detect and encode
   // --------------------
   assign hit = |hits;

   always_comb begin
      hit_way = '0;
      for (int w = 0; w < NUM_WAYS; w++)
         if (hits[w])
            hit_way = way_t'(w);
   end

   // Fills never place a line in a second way
   a_one_way: assert property (@(posedge clock) disable iff (reset)
      $onehot0(hits));

endmodule

`default_nettype wire

/* src/dcache_data.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_data
   import dcache_pkg::*;
(
   input  logic        clock,
   input  way_t        hit_way,
   input  line_index_t lookup_index,
   input  word_index_t lookup_word,
   input  logic        cache_write,
   input  word_t       store_lanes,
   input  byte_en_t    store_byteena,
   input  way_t        fill_way,
   input  line_index_t fill_index,
   input  word_index_t fill_word,
   input  logic        mem_readdatavalid,
   input  word_t       mem_readdata,
   output word_t       read_word
);

   localparam int ADDR_BITS = WAY_BITS + LINE_INDEX_BITS + WORD_INDEX_BITS;

   word_t                ram [1 << ADDR_BITS];
   line_index_t          access_index;
   logic [ADDR_BITS-1:0] access_addr;
   logic [ADDR_BITS-1:0] fill_addr;

   // Index arrives with the request, way and word one cycle later
   always_ff @(posedge clock)
      access_index <= lookup_index;

   assign access_addr = {hit_way, access_index, lookup_word};
   assign fill_addr   = {fill_way, fill_index, fill_word};

   // Port A is store hits and load reads, port B is line fill
   always_ff @(posedge clock) begin
      if (cache_write) begin
         for (int b = 0; b < 4; b++)
            if (store_byteena[b])
               ram[access_addr][8*b +: 8] <= store_lanes[8*b +: 8];
      end
      if (mem_readdatavalid)
         ram[fill_addr] <= mem_readdata;
      read_word <= ram[access_addr];
   end

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic        req_valid,
   input  opcode_t     req_opcode,
   input  byte_addr_t  req_address,
   input  word_t       req_store_data,
   output logic        resp_valid,
   output logic        resp_restart,
   output logic        mem_read,
   output logic        mem_write,
   output word_addr_t  mem_address,
   output word_t       mem_writedata,
   output byte_en_t    mem_byteenable,
   input  logic        mem_waitrequest,
   input  logic        mem_readdatavalid,
   input  logic        hit,
   input  way_t        hit_way,
   output tag_t        lookup_tag,
   output word_index_t lookup_word,
   output line_index_t lookup_index,
   output logic        cache_write,
   output way_t        fill_way,
   output line_index_t fill_index,
   output word_index_t fill_word,
   output tag_t        fill_tag,
   output logic        tag_invalidate,
   output logic        tag_write,
   output opcode_t     load_op,
   output logic [1:0]  load_byte,
   output opcode_t     store_op,
   output logic [1:0]  store_byte,
   output word_t       store_data,
   output word_addr_t  store_address,
   output logic        sb_push,
   output logic        sb_pop,
   input  logic        sb_full,
   input  logic        sb_empty,
   input  word_addr_t  sb_address,
   input  word_t       sb_data,
   input  byte_en_t    sb_byteena
);

   // Byte address split  | tag | line | word | byte |
   localparam int LINE_LSB = WORD_INDEX_BITS + 2;
   localparam int TAG_LSB  = LINE_LSB + LINE_INDEX_BITS;
   localparam int PAD_BITS = $bits(word_addr_t) - (CACHEABLE_BITS - 2);

   ctrl_state_t state;
   logic        x_valid;
   opcode_t     x_opcode;
   byte_addr_t  x_address;
   word_t       x_store_data;
   line_index_t x_index;
   logic        x_load;
   logic        x_store;
   logic        load_miss;
   logic        fill_conflict;
   logic        store_ok;
   logic        issue_write;
   logic        issue_fill;
   logic        tag_written;
   logic        start_fill;
   logic [32:0] lfsr;

   // --------------------
   // Lookup stage
   // --------------------
   always_ff @(posedge clock) begin
      if (reset)
         x_valid <= 1'b0;
      else
         x_valid <= req_valid;
   end

   always_ff @(posedge clock) begin
      x_opcode     <= req_opcode;
      x_address    <= req_address;
      x_store_data <= req_store_data;
   end

   // Tag RAM is addressed straight from the request
   assign lookup_index = req_address[TAG_LSB-1:LINE_LSB];
   assign lookup_tag   = x_address[CACHEABLE_BITS-1:TAG_LSB];
   assign lookup_word  = x_address[LINE_LSB-1:2];
   assign x_index      = x_address[TAG_LSB-1:LINE_LSB];

   assign x_load  = x_valid && (x_opcode inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});
   assign x_store = x_valid && (x_opcode inside {OP_SB, OP_SH, OP_SW});
   assign load_miss = x_load && !hit;

   // A store to the line being fetched would be lost under the fill data
   // Tags still show the old line in the cycle after the last beat
   assign fill_conflict = (state == S_FILL_REQ || state == S_FILL || tag_written) &&
                          lookup_tag == fill_tag && x_index == fill_index;
   assign store_ok = x_store && !sb_full && !fill_conflict;

   // Write-through, no-write-allocate
   assign sb_push     = store_ok;
   assign cache_write = store_ok && hit;

   assign store_op      = x_opcode;
   assign store_byte    = x_address[1:0];
   assign store_data    = x_store_data;
   assign store_address = {{PAD_BITS{1'b0}}, x_address[CACHEABLE_BITS-1:2]};

   // --------------------
   // Access stage
   // --------------------
   always_ff @(posedge clock) begin
      if (reset) begin
         resp_valid   <= 1'b0;
         resp_restart <= 1'b0;
      end else begin
         resp_valid   <= (x_load && hit) || store_ok;
         resp_restart <= load_miss || (x_store && !store_ok);
      end
   end

   // Steers the load extraction during the data read
   always_ff @(posedge clock) begin
      load_op   <= x_opcode;
      load_byte <= x_address[1:0];
   end

   // --------------------
   // Miss FSM
   // --------------------
   // Victim way is cleared for as long as the drain lasts
   assign tag_invalidate = state == S_DRAIN;
   assign tag_write = state == S_FILL && mem_readdatavalid && &fill_word;

   // No new fill while the tag read still predates the last one
   assign start_fill = state == S_IDLE && load_miss && !tag_written;

   always_ff @(posedge clock) begin
      if (reset)
         tag_written <= 1'b0;
      else
         tag_written <= tag_write;
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state     <= S_IDLE;
         lfsr      <= '0;
         fill_word <= '0;
      end else begin
         lfsr <= {lfsr[31:0], ~lfsr[32] ^ lfsr[19]};
         case (state)
            S_IDLE:
               if (start_fill)
                  state <= S_DRAIN;
            S_DRAIN:
               if (sb_empty)
                  state <= S_FILL_REQ;
            S_FILL_REQ:
               if (issue_fill)
                  state <= S_FILL;
            S_FILL:
               // Word counter wraps back to zero after the last beat
               if (mem_readdatavalid) begin
                  fill_word <= fill_word + 1'b1;
                  if (&fill_word)
                     state <= S_IDLE;
               end
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // Line to fetch, latched on the miss that starts it
   always_ff @(posedge clock) begin
      if (start_fill) begin
         fill_tag   <= lookup_tag;
         fill_index <= x_index;
         fill_way   <= lfsr[WAY_BITS-1:0];
      end
   end

   // --------------------
   // Memory port
   // --------------------
   // Stores always go first so a fill sees every earlier write
   assign issue_write = !mem_waitrequest && !sb_empty;
   assign issue_fill  = !mem_waitrequest && sb_empty && state == S_FILL_REQ;
   assign sb_pop      = issue_write;

   always_ff @(posedge clock) begin
      if (reset) begin
         mem_read  <= 1'b0;
         mem_write <= 1'b0;
      end else if (!mem_waitrequest) begin
         mem_write <= issue_write;
         mem_read  <= issue_fill;
      end
   end

   always_ff @(posedge clock) begin
      if (issue_write) begin
         mem_address    <= sb_address;
         mem_writedata  <= sb_data;
         mem_byteenable <= sb_byteena;
      end else if (issue_fill) begin
         mem_address <= {{PAD_BITS{1'b0}}, fill_tag, fill_index, {WORD_INDEX_BITS{1'b0}}};
      end
   end

   // Only one memory command at a time
   a_mem_excl: assert property (@(posedge clock) disable iff (reset)
      !(mem_read && mem_write));

   // Each request slot carries a single answer
   a_resp_excl: assert property (@(posedge clock) disable iff (reset)
      !(resp_valid && resp_restart));

   // The victim way stays invalid until its tag is written
   a_no_victim_hit: assert property (@(posedge clock) disable iff (reset)
      (state == S_FILL && x_valid && hit && x_index == fill_index) |-> hit_way != fill_way);

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top
   import dcache_pkg::*;
#(
   parameter int SB_DEPTH_BITS = 3
) (
   input  logic       clock,
   input  logic       reset,
   // Client request and response
   input  logic       req_valid,
   input  opcode_t    req_opcode,
   input  byte_addr_t req_address,
   input  word_t      req_store_data,
   output logic       resp_valid,
   output logic       resp_restart,
   output word_t      resp_data,
   // Main memory
   output logic       mem_read,
   output logic       mem_write,
   output word_addr_t mem_address,
   output word_t      mem_writedata,
   output byte_en_t   mem_byteenable,
   input  logic       mem_waitrequest,
   input  logic       mem_readdatavalid,
   input  word_t      mem_readdata
);

   // Tag lookup
   logic        hit;
   way_t        hit_way;
   tag_t        lookup_tag;
   word_index_t lookup_word;
   line_index_t lookup_index;
   logic        cache_write;

   // Line fill
   way_t        fill_way;
   line_index_t fill_index;
   word_index_t fill_word;
   tag_t        fill_tag;
   logic        tag_invalidate;
   logic        tag_write;

   // Store and load formatting
   opcode_t     load_op;
   logic [1:0]  load_byte;
   opcode_t     store_op;
   logic [1:0]  store_byte;
   word_t       store_data;
   word_addr_t  store_address;
   word_t       store_lanes;
   byte_en_t    store_byteena;
   word_t       read_word;

   // Store buffer
   logic        sb_push;
   logic        sb_pop;
   logic        sb_full;
   logic        sb_empty;
   word_addr_t  sb_address;
   word_t       sb_data;
   byte_en_t    sb_byteena;

   dcache_ctrl ctrl (
      .clock, .reset,
      .req_valid, .req_opcode, .req_address, .req_store_data,
      .resp_valid, .resp_restart,
      .mem_read, .mem_write, .mem_address, .mem_writedata, .mem_byteenable,
      .mem_waitrequest, .mem_readdatavalid,
      .hit, .hit_way,
      .lookup_tag, .lookup_word, .lookup_index, .cache_write,
      .fill_way, .fill_index, .fill_word, .fill_tag, .tag_invalidate, .tag_write,
      .load_op, .load_byte,
      .store_op, .store_byte, .store_data, .store_address,
      .sb_push, .sb_pop, .sb_full, .sb_empty, .sb_address, .sb_data, .sb_byteena
   );

   dcache_tags tags (
      .clock, .reset,
      .lookup_index, .lookup_tag,
      .fill_way, .fill_index, .fill_tag, .tag_invalidate, .tag_write,
      .hit, .hit_way
   );

   dcache_data data (
      .clock,
      .hit_way, .lookup_index, .lookup_word, .cache_write,
      .store_lanes, .store_byteena,
      .fill_way, .fill_index, .fill_word,
      .mem_readdatavalid, .mem_readdata,
      .read_word
   );

   dcache_align align (
      .store_op, .store_byte, .store_data, .store_lanes, .store_byteena,
      .load_op, .load_byte, .read_word,
      .load_result (resp_data)
   );

   store_buffer #(
      .SB_DEPTH_BITS (SB_DEPTH_BITS)
   ) sb (
      .clock, .reset,
      .push         (sb_push),
      .push_address (store_address),
      .push_data    (store_lanes),
      .push_byteena (store_byteena),
      .pop          (sb_pop),
      .full         (sb_full),
      .empty        (sb_empty),
      .head_address (sb_address),
      .head_data    (sb_data),
      .head_byteena (sb_byteena)
   );

endmodule

`default_nettype wire

/* dv/tb_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_memory
   import dcache_pkg::*;
(
   input  logic       clock,
   input  logic       mem_read,
   input  logic       mem_write,
   input  word_addr_t mem_address,
   input  word_t      mem_writedata,
   input  byte_en_t   mem_byteenable,
   input  logic       mem_waitrequest,
   output logic       mem_readdatavalid,
   output word_t      mem_readdata
);

   // Sparse storage, untouched words read back the fill pattern
   word_t      mem [word_addr_t];
   int         burst_left;
   word_addr_t burst_addr;
   int         reads_seen;
   int         writes_seen;
   word_addr_t last_read_address;
   // Accepted writes in arrival order
   word_addr_t wr_addr_log [$];
   word_t      wr_data_log [$];
   byte_en_t   wr_be_log [$];

   // Pattern mixes every address bit
   function automatic word_t fill_pattern(word_addr_t a);
      return word_t'({2'b01, a}) * 32'h9E37_79B1 + 32'h0000_1357;
   endfunction

   function automatic word_t peek(word_addr_t a);
      return mem.exists(a) ? mem[a] : fill_pattern(a);
   endfunction

   initial begin
      mem_readdatavalid = 1'b0;
      mem_readdata = '0;
      burst_left = 0;
      reads_seen = 0;
      writes_seen = 0;
   end

   // --------------------
   // Command acceptance
   // --------------------
   always @(posedge clock) begin
      word_t w;
      if (!mem_waitrequest && mem_write) begin
         w = peek(mem_address);
         // Lane 3 is the lowest byte address
         for (int b = 0; b < 4; b++)
            if (mem_byteenable[b])
               w[8*b +: 8] = mem_writedata[8*b +: 8];
         mem[mem_address] = w;
         wr_addr_log.push_back(mem_address);
         wr_data_log.push_back(mem_writedata);
         wr_be_log.push_back(mem_byteenable);
         writes_seen++;
      end
      if (!mem_waitrequest && mem_read) begin
         burst_left = 8;
         burst_addr = mem_address;
         last_read_address = mem_address;
         reads_seen++;
      end
   end

   // Burst beats go out on the falling edge, one per cycle
   always @(negedge clock) begin
      if (burst_left > 0) begin
         mem_readdatavalid = 1'b1;
         mem_readdata = peek(burst_addr);
         burst_addr = burst_addr + 1'b1;
         burst_left--;
      end else begin
         mem_readdatavalid = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top
   import dcache_pkg::*;
();

   logic       clock;
   logic       reset;
   logic       req_valid;
   opcode_t    req_opcode;
   byte_addr_t req_address;
   word_t      req_store_data;
   logic       resp_valid;
   logic       resp_restart;
   word_t      resp_data;
   logic       mem_read;
   logic       mem_write;
   word_addr_t mem_address;
   word_t      mem_writedata;
   byte_en_t   mem_byteenable;
   logic       mem_waitrequest;
   logic       mem_readdatavalid;
   word_t      mem_readdata;

   // Request pipeline copy, response due in the s2 slot
   logic       s1_valid;
   logic       s2_valid;
   opcode_t    s1_op;
   opcode_t    s2_op;
   byte_addr_t s1_addr;
   byte_addr_t s2_addr;
   word_t      s1_data;
   word_t      s2_data;

   word_t       shadow [int];
   logic [31:0] lfsr;
   logic [69:0] work [$];
   logic [69:0] retry [$];
   logic        retry_on;
   logic        last_restart;
   int          outcomes;
   int          accepted;
   int          stores_accepted;
   int          stall_mode;
   event        checked;

   dcache_top #(.SB_DEPTH_BITS(3)) dut (.*);

   tb_memory mem_model (.*);

   always #5 clock = ~clock;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   task automatic abort(input string why);
      $display("%s at %0t", why, $time);
      $display("Something failed");
      $fatal(1);
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // --------------------
   // Reference model
   // --------------------
   function automatic word_t shadow_word(input int wa);
      return shadow.exists(wa) ? shadow[wa] : mem_model.fill_pattern(word_addr_t'(wa));
   endfunction

   // Big-endian, offset 0 is bits 31:24
   function automatic word_t expected_load(word_t w, opcode_t op, logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[31 - 8*off -: 8];
      h = w[31 - 16*off[1] -: 16];
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'h0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'h0, h};
         default: return w;
      endcase
   endfunction

   function automatic byte_en_t expected_enables(opcode_t op, logic [1:0] off);
      byte_en_t be;
      be = '0;
      if (op == OP_SB)
         be[3 - off] = 1'b1;
      else if (op == OP_SH) begin
         be[3 - off] = 1'b1;
         be[2 - off] = 1'b1;
      end else
         be = 4'hF;
      return be;
   endfunction

   function automatic word_t expected_lanes(opcode_t op, word_t d);
      if (op == OP_SB)
         return {4{d[7:0]}};
      else if (op == OP_SH)
         return {2{d[15:0]}};
      return d;
   endfunction

   function automatic word_t merge_store(word_t old, opcode_t op, logic [1:0] off, word_t d);
      byte_en_t be;
      word_t    lanes;
      be = expected_enables(op, off);
      lanes = expected_lanes(op, d);
      for (int b = 0; b < 4; b++)
         if (be[b])
            old[8*b +: 8] = lanes[8*b +: 8];
      return old;
   endfunction

   // Inputs are stable at the rising edge
   always @(posedge clock) begin
      s2_valid = s1_valid;
      s2_op = s1_op;
      s2_addr = s1_addr;
      s2_data = s1_data;
      s1_valid = req_valid;
      s1_op = req_opcode;
      s1_addr = req_address;
      s1_data = req_store_data;
   end

   // --------------------
   // Response compare
   // --------------------
   always @(negedge clock) begin
      int wa;
      wa = int'(s2_addr[19:2]);
      if (!reset && s2_valid) begin
         if (resp_valid === resp_restart)
            abort("Request slot without exactly one of resp_valid and resp_restart");
         last_restart = resp_restart;
         outcomes++;
         if (resp_restart) begin
            if (retry_on)
               retry.push_back({s2_op, s2_addr, s2_data});
         end else if (s2_op inside {OP_SB, OP_SH, OP_SW}) begin
            shadow[wa] = merge_store(shadow_word(wa), s2_op, s2_addr[1:0], s2_data);
            stores_accepted++;
            accepted++;
         end else begin
            check_value("resp_data", resp_data,
                        expected_load(shadow_word(wa), s2_op, s2_addr[1:0]));
            accepted++;
         end
      end else if (!reset) begin
         check_value("resp_valid", resp_valid, 0);
         check_value("resp_restart", resp_restart, 0);
      end
      -> checked;
   end

   // One falling edge, after the compare
   task automatic step();
      @(checked);
      if (stall_mode == 1)
         mem_waitrequest = 1'b1;
      else if (stall_mode == 2)
         mem_waitrequest = random_bits(2) == 2'b00;
      else
         mem_waitrequest = 1'b0;
      req_valid = 1'b0;
   endtask

   task automatic drive(input logic [69:0] r);
      req_valid = 1'b1;
      {req_opcode, req_address, req_store_data} = r;
   endtask

   task automatic issue_once(input opcode_t op, input byte_addr_t a, input word_t d,
                             output logic restarted);
      int start;
      int t;
      step();
      start = outcomes;
      drive({op, a, d});
      t = 0;
      while (outcomes == start) begin
         if (t == 10)
            abort("No response to a request");
         step();
         t++;
      end
      restarted = last_restart;
   endtask

   task automatic access(input opcode_t op, input byte_addr_t a, input word_t d);
      logic restarted;
      int   tries;
      restarted = 1'b1;
      tries = 0;
      while (restarted) begin
         if (tries == 200)
            abort("Request kept being restarted");
         issue_once(op, a, d, restarted);
         tries++;
      end
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (mem_model.writes_seen != stores_accepted) begin
         if (t == 5000)
            abort("Store buffer never drained to memory");
         step();
         t++;
      end
   endtask

   task automatic check_write(input opcode_t op, input byte_addr_t a, input word_t d);
      int t;
      t = 0;
      while (mem_model.wr_addr_log.size() == 0) begin
         if (t == 1000)
            abort("Store never reached the memory write port");
         step();
         t++;
      end
      check_value("mem_address", mem_model.wr_addr_log.pop_front(), a[19:2]);
      check_value("mem_writedata", mem_model.wr_data_log.pop_front(), expected_lanes(op, d));
      check_value("mem_byteenable", mem_model.wr_be_log.pop_front(),
                  expected_enables(op, a[1:0]));
   endtask

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      opcode_t     ops [8];
      logic        restarted;
      int          reads0;
      int          t;
      int          target;
      byte_addr_t  a;
      opcode_t     op;
      word_addr_t  expect_addr [$];
      ops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
      clock = 1'b0;
      reset = 1'b1;
      req_valid = 1'b0;
      req_opcode = OP_LW;
      req_address = '0;
      req_store_data = '0;
      mem_waitrequest = 1'b0;
      lfsr = 32'he71a;
      retry_on = 1'b0;
      outcomes = 0;
      accepted = 0;
      stores_accepted = 0;
      stall_mode = 0;
      for (int i = 0; i < 10; i++)
         @(negedge clock);
      reset = 1'b0;

      // Quiet after reset
      for (int i = 0; i < 20; i++) begin
         step();
         check_value("mem_read", mem_read, 0);
         check_value("mem_write", mem_write, 0);
      end

      // Miss, burst, then hit
      reads0 = mem_model.reads_seen;
      issue_once(OP_LW, 32'h0000_1244, 0, restarted);
      check_value("resp_restart", restarted, 1);
      t = 0;
      while (mem_model.reads_seen == reads0) begin
         if (t == 100)
            abort("No burst read after a load miss");
         step();
         t++;
      end
      check_value("mem_address", mem_model.last_read_address, 30'h0000_0490);
      access(OP_LW, 32'h0000_1244, 0);
      issue_once(OP_LW, 32'h0000_125C, 0, restarted);
      check_value("resp_restart", restarted, 0);

      // Every load opcode at every legal offset
      for (int off = 0; off < 4; off++) begin
         access(OP_LB, 32'h0000_1248 + off, 0);
         access(OP_LBU, 32'h0000_1248 + off, 0);
      end
      for (int off = 0; off < 4; off += 2) begin
         access(OP_LH, 32'h0000_124C + off, 0);
         access(OP_LHU, 32'h0000_124C + off, 0);
      end

      // Stores to a cached and an uncached line
      for (int off = 0; off < 4; off++) begin
         access(OP_SB, 32'h0000_1250 + off, 32'h0000_0080 + off);
         check_write(OP_SB, 32'h0000_1250 + off, 32'h0000_0080 + off);
      end
      access(OP_SH, 32'h0000_1256, 32'h0000_F00D);
      check_write(OP_SH, 32'h0000_1256, 32'h0000_F00D);
      access(OP_SW, 32'h0004_0000, 32'hCAFE_1234);
      check_write(OP_SW, 32'h0004_0000, 32'hCAFE_1234);
      access(OP_SH, 32'h0004_0004, 32'h0000_8001);
      check_write(OP_SH, 32'h0004_0004, 32'h0000_8001);
      access(OP_LW, 32'h0000_1250, 0);
      access(OP_LH, 32'h0000_1256, 0);
      access(OP_LW, 32'h0004_0004, 0);
      wait_drain();
      foreach (shadow[w])
         check_value("memory word", mem_model.peek(word_addr_t'(w)), shadow[w]);

      // Full store buffer under a stalled memory
      stall_mode = 1;
      for (int i = 0; i < 7; i++) begin
         issue_once(OP_SW, 32'h0002_0000 + 4*i, 32'h1111_0000 + i, restarted);
         check_value("resp_restart", restarted, 0);
         expect_addr.push_back(word_addr_t'((32'h0002_0000 + 4*i) >> 2));
      end
      issue_once(OP_SW, 32'h0002_0100, 32'h2222_0000, restarted);
      check_value("resp_restart", restarted, 1);
      stall_mode = 0;
      wait_drain();
      foreach (expect_addr[i]) begin
         check_value("mem_address", mem_model.wr_addr_log.pop_front(), expect_addr[i]);
         check_value("mem_writedata", mem_model.wr_data_log.pop_front(), 32'h1111_0000 + i);
         void'(mem_model.wr_be_log.pop_front());
      end
      access(OP_SW, 32'h0002_0100, 32'h2222_0000);

      // Random back-to-back mix with memory stalls
      for (int i = 0; i < 400; i++) begin
         op = ops[random_bits(3)];
         a = {12'h0, 7'h0, 3'(random_bits(3)), 3'h0, 2'(random_bits(2)),
              3'(random_bits(3)), 2'b00};
         if (op inside {OP_LB, OP_LBU, OP_SB})
            a[1:0] = random_bits(2);
         else if (op inside {OP_LH, OP_LHU, OP_SH})
            a[1] = random_bits(1);
         work.push_back({op, a, random_bits(32)});
      end
      stall_mode = 2;
      retry_on = 1'b1;
      target = accepted + 400;
      t = 0;
      while (accepted != target) begin
         if (t == 200000)
            abort("Random mix did not complete");
         step();
         if (retry.size() != 0)
            drive(retry.pop_front());
         else if (work.size() != 0)
            drive(work.pop_front());
         t++;
      end
      step();
      step();
      retry_on = 1'b0;
      stall_mode = 0;
      wait_drain();
      foreach (shadow[w])
         check_value("memory word", mem_model.peek(word_addr_t'(w)), shadow[w]);

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
src/dcache_pkg.sv
src/dcache_align.sv
src/store_buffer.sv
src/dcache_tags.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/dcache_top.sv
dv/tb_memory.sv
dv/tb_top.sv
